//--- hdl/isa_pkg.sv
package isa_pkg;

    // Major opcodes
    localparam logic [6:0] R_OP       = 7'b0110011;
    localparam logic [6:0] I_MEM_OP   = 7'b0000011;
    localparam logic [6:0] I_LOGIC_OP = 7'b0010011;
    localparam logic [6:0] I_JALR_OP  = 7'b1100111;
    localparam logic [6:0] S_OP       = 7'b0100011;
    localparam logic [6:0] B_OP       = 7'b1100011;
    localparam logic [6:0] U_LUI_OP   = 7'b0110111;
    localparam logic [6:0] U_AUIPC_OP = 7'b0010111;
    localparam logic [6:0] J_OP       = 7'b1101111;

    typedef enum logic [1:0] {
        FU_NONE = 2'd0,
        FU_ALU  = 2'd1,
        FU_LSQ  = 2'd2,
        FU_BRA  = 2'd3
    } fu_t;

    // OUTB passes operand B through, for lui
    typedef enum logic [3:0] {
        ADD     = 4'd0,
        SUB     = 4'd1,
        AND     = 4'd2,
        OR      = 4'd3,
        XOR     = 4'd4,
        SLL     = 4'd5,
        SRL     = 4'd6,
        SRA     = 4'd7,
        SLT     = 4'd8,
        SLTU    = 4'd9,
        OUTB    = 4'd10,
        ALU_NOP = 4'd15
    } alu_op_t;

    typedef enum logic [3:0] {
        LB      = 4'd0,
        LBU     = 4'd1,
        LH      = 4'd2,
        LHU     = 4'd3,
        LW      = 4'd4,
        SB      = 4'd5,
        SH      = 4'd6,
        SW      = 4'd7,
        LSQ_NOP = 4'd15
    } lsq_op_t;

    typedef enum logic [3:0] {
        BEQ     = 4'd0,
        BNE     = 4'd1,
        BLT     = 4'd2,
        BGE     = 4'd3,
        BLTU    = 4'd4,
        BGEU    = 4'd5,
        JAL     = 4'd6,
        JALR    = 4'd7,
        BRA_NOP = 4'd15
    } bra_op_t;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_sel_t;

    typedef enum logic [1:0] {
        OPA_NONE = 2'd0,
        OPA_PC   = 2'd1,
        OPA_REG  = 2'd2
    } opa_sel_t;

    typedef enum logic [1:0] {
        OPB_NONE = 2'd0,
        OPB_IMM  = 2'd1,
        OPB_REG  = 2'd2
    } opb_sel_t;

    // Immediate is sign-extended and already shifted for B, U and J
    typedef struct packed {
        logic        legal;
        fu_t         fu;
        alu_op_t     alu_op;
        lsq_op_t     lsq_op;
        bra_op_t     bra_op;
        imm_sel_t    imm_sel;
        opa_sel_t    opa_sel;
        opb_sel_t    opb_sel;
        logic        reg_write;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
    } uop_t;

endpackage

//--- hdl/pipe_pkg.sv
package pipe_pkg;

    // 32-entry reorder buffer
    localparam int ROB_TAG_W = 5;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // One instruction slot of a fetch group
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_slot_t;

    // Micro-op on its way to the function units
    typedef struct packed {
        logic          valid;
        rob_tag_t      tag;
        logic [31:0]   pc;
        isa_pkg::uop_t uop;
    } disp_uop_t;

endpackage

//--- hdl/fetch_align.sv
module fetch_align #(
    parameter int LANES = 4
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              fetch_valid,
    input  logic [31:0]                       fetch_pc,
    input  logic [LANES-1:0][31:0]            fetch_insts,
    input  logic [LANES-1:0]                  fetch_mask,
    input  logic                              stall,
    output pipe_pkg::fetch_slot_t [LANES-1:0] slots,
    output logic                              slots_valid
);

    logic [31:0]            grp_pc;
    logic [LANES-1:0][31:0] grp_insts;
    logic [LANES-1:0]       grp_mask;
    logic                   load;

    // New groups are ignored while the held one waits
    assign load = fetch_valid && !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slots_valid <= 1'b0;
        end else if (!stall) begin
            slots_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            grp_pc    <= fetch_pc;
            grp_insts <= fetch_insts;
            grp_mask  <= fetch_mask;
        end
    end

    // Lane i sits at base pc plus 4*i
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            slots[i].valid = grp_mask[i];
            slots[i].pc    = grp_pc + 32'(i * 4);
            slots[i].inst  = grp_insts[i];
        end
    end

endmodule

//--- hdl/inst_decoder.sv
module inst_decoder (
    input  logic [31:0]   inst,
    output isa_pkg::uop_t uop
);

    import isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [31:0] imm;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // R type
    logic is_add, is_sub, is_sll, is_slt, is_sltu, is_xor, is_srl, is_sra, is_or, is_and;
    assign is_add  = (opcode == R_OP) && (funct3 == 3'h0) && (funct7 == 7'h00);
    assign is_sub  = (opcode == R_OP) && (funct3 == 3'h0) && (funct7 == 7'h20);
    assign is_sll  = (opcode == R_OP) && (funct3 == 3'h1) && (funct7 == 7'h00);
    assign is_slt  = (opcode == R_OP) && (funct3 == 3'h2) && (funct7 == 7'h00);
    assign is_sltu = (opcode == R_OP) && (funct3 == 3'h3) && (funct7 == 7'h00);
    assign is_xor  = (opcode == R_OP) && (funct3 == 3'h4) && (funct7 == 7'h00);
    assign is_srl  = (opcode == R_OP) && (funct3 == 3'h5) && (funct7 == 7'h00);
    assign is_sra  = (opcode == R_OP) && (funct3 == 3'h5) && (funct7 == 7'h20);
    assign is_or   = (opcode == R_OP) && (funct3 == 3'h6) && (funct7 == 7'h00);
    assign is_and  = (opcode == R_OP) && (funct3 == 3'h7) && (funct7 == 7'h00);

    // Loads
    logic is_lb, is_lh, is_lw, is_lbu, is_lhu;
    assign is_lb  = (opcode == I_MEM_OP) && (funct3 == 3'h0);
    assign is_lh  = (opcode == I_MEM_OP) && (funct3 == 3'h1);
    assign is_lw  = (opcode == I_MEM_OP) && (funct3 == 3'h2);
    assign is_lbu = (opcode == I_MEM_OP) && (funct3 == 3'h4);
    assign is_lhu = (opcode == I_MEM_OP) && (funct3 == 3'h5);

    // Register-immediate ALU ops
    logic is_addi, is_slti, is_sltiu, is_xori, is_ori, is_andi, is_slli, is_srli, is_srai;
    assign is_addi  = (opcode == I_LOGIC_OP) && (funct3 == 3'h0);
    assign is_slti  = (opcode == I_LOGIC_OP) && (funct3 == 3'h2);
    assign is_sltiu = (opcode == I_LOGIC_OP) && (funct3 == 3'h3);
    assign is_xori  = (opcode == I_LOGIC_OP) && (funct3 == 3'h4);
    assign is_ori   = (opcode == I_LOGIC_OP) && (funct3 == 3'h6);
    assign is_andi  = (opcode == I_LOGIC_OP) && (funct3 == 3'h7);
    assign is_slli  = (opcode == I_LOGIC_OP) && (funct3 == 3'h1) && (funct7 == 7'h00);
    assign is_srli  = (opcode == I_LOGIC_OP) && (funct3 == 3'h5) && (funct7 == 7'h00);
    assign is_srai  = (opcode == I_LOGIC_OP) && (funct3 == 3'h5) && (funct7 == 7'h20);

    logic is_jalr, is_sb, is_sh, is_sw;
    assign is_jalr = (opcode == I_JALR_OP) && (funct3 == 3'h0);
    assign is_sb   = (opcode == S_OP) && (funct3 == 3'h0);
    assign is_sh   = (opcode == S_OP) && (funct3 == 3'h1);
    assign is_sw   = (opcode == S_OP) && (funct3 == 3'h2);

    // Branches and jumps
    logic is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu, is_lui, is_auipc, is_jal;
    assign is_beq   = (opcode == B_OP) && (funct3 == 3'h0);
    assign is_bne   = (opcode == B_OP) && (funct3 == 3'h1);
    assign is_blt   = (opcode == B_OP) && (funct3 == 3'h4);
    assign is_bge   = (opcode == B_OP) && (funct3 == 3'h5);
    assign is_bltu  = (opcode == B_OP) && (funct3 == 3'h6);
    assign is_bgeu  = (opcode == B_OP) && (funct3 == 3'h7);
    assign is_lui   = (opcode == U_LUI_OP);
    assign is_auipc = (opcode == U_AUIPC_OP);
    assign is_jal   = (opcode == J_OP);

    logic is_r, is_i_mem, is_i_logic, is_i, is_s, is_b, is_u, is_j, is_legal;
    assign is_r = is_add | is_sub | is_sll | is_slt | is_sltu | is_xor
                | is_srl | is_sra | is_or | is_and;
    assign is_i_mem   = is_lb | is_lh | is_lw | is_lbu | is_lhu;
    assign is_i_logic = is_addi | is_slti | is_sltiu | is_xori | is_ori | is_andi
                      | is_slli | is_srli | is_srai;
    assign is_i = is_i_mem | is_i_logic | is_jalr;
    assign is_s = is_sb | is_sh | is_sw;
    assign is_b = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;
    assign is_u = is_lui | is_auipc;
    assign is_j = is_jal;
    assign is_legal = is_r | is_i | is_s | is_b | is_u | is_j;

    always_comb begin
        uop = '0;
        uop.legal     = is_legal;
        uop.reg_write = is_r | is_i | is_u | is_j;
        uop.rd        = inst[11:7];
        uop.rs1       = inst[19:15];
        uop.rs2       = inst[24:20];

        if (is_r | is_i_logic | is_u)    uop.fu = FU_ALU;
        else if (is_i_mem | is_s)        uop.fu = FU_LSQ;
        else if (is_b | is_j | is_jalr)  uop.fu = FU_BRA;
        else                             uop.fu = FU_NONE;

        if (is_i)      uop.imm_sel = IMM_I;
        else if (is_s) uop.imm_sel = IMM_S;
        else if (is_b) uop.imm_sel = IMM_B;
        else if (is_u) uop.imm_sel = IMM_U;
        else if (is_j) uop.imm_sel = IMM_J;
        else           uop.imm_sel = IMM_NONE;

        // Branches and jalr read rs1 inside the branch unit
        if (is_auipc)                                uop.opa_sel = OPA_PC;
        else if (is_r | is_i_mem | is_i_logic | is_s) uop.opa_sel = OPA_REG;
        else                                          uop.opa_sel = OPA_NONE;

        if (is_i_logic | is_u)       uop.opb_sel = OPB_IMM;
        else if (is_r | is_b | is_s) uop.opb_sel = OPB_REG;
        else                         uop.opb_sel = OPB_NONE;

        if (is_add | is_addi | is_auipc)  uop.alu_op = ADD;
        else if (is_sub)                  uop.alu_op = SUB;
        else if (is_and | is_andi)        uop.alu_op = AND;
        else if (is_or | is_ori)          uop.alu_op = OR;
        else if (is_xor | is_xori)        uop.alu_op = XOR;
        else if (is_sll | is_slli)        uop.alu_op = SLL;
        else if (is_srl | is_srli)        uop.alu_op = SRL;
        else if (is_sra | is_srai)        uop.alu_op = SRA;
        else if (is_slt | is_slti)        uop.alu_op = SLT;
        else if (is_sltu | is_sltiu)      uop.alu_op = SLTU;
        else if (is_lui)                  uop.alu_op = OUTB;
        else                              uop.alu_op = ALU_NOP;

        if (is_lb)       uop.lsq_op = LB;
        else if (is_lbu) uop.lsq_op = LBU;
        else if (is_lh)  uop.lsq_op = LH;
        else if (is_lhu) uop.lsq_op = LHU;
        else if (is_lw)  uop.lsq_op = LW;
        else if (is_sb)  uop.lsq_op = SB;
        else if (is_sh)  uop.lsq_op = SH;
        else if (is_sw)  uop.lsq_op = SW;
        else             uop.lsq_op = LSQ_NOP;

        if (is_beq)       uop.bra_op = BEQ;
        else if (is_bne)  uop.bra_op = BNE;
        else if (is_blt)  uop.bra_op = BLT;
        else if (is_bge)  uop.bra_op = BGE;
        else if (is_bltu) uop.bra_op = BLTU;
        else if (is_bgeu) uop.bra_op = BGEU;
        else if (is_jal)  uop.bra_op = JAL;
        else if (is_jalr) uop.bra_op = JALR;
        else              uop.bra_op = BRA_NOP;

        uop.imm = imm;
    end

    // Immediate by format
    always_comb begin
        unique case (uop.imm_sel)
            IMM_I:   imm = {{20{inst[31]}}, inst[31:20]};
            IMM_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            IMM_B:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U:   imm = {inst[31:12], 12'b0};
            IMM_J:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

//--- hdl/dispatch_unit.sv
module dispatch_unit #(
    parameter int LANES = 4
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  pipe_pkg::fetch_slot_t [LANES-1:0] slots,
    input  logic                              slots_valid,
    input  isa_pkg::uop_t [LANES-1:0]         uops,
    input  logic [5:0]                        rob_free,
    output logic                              stall,
    output pipe_pkg::disp_uop_t [LANES-1:0]   disp,
    output logic                              disp_valid
);

    import pipe_pkg::*;

    logic [LANES-1:0]       lane_ok;
    rob_tag_t [LANES-1:0]   lane_tag;
    logic [5:0]             need;
    rob_tag_t               tail;
    rob_tag_t               tail_next;
    logic                   fire;
    logic [LANES-1:0]       vld_q;
    disp_uop_t [LANES-1:0]  disp_q;

    // Running prefix count gives program-order tags from the tail
    always_comb begin
        rob_tag_t   run;
        logic [5:0] cnt;

        run = tail;
        cnt = '0;
        for (int i = 0; i < LANES; i++) begin
            lane_ok[i]  = slots[i].valid & uops[i].legal;
            lane_tag[i] = lane_ok[i] ? run : '0;
            run         = run + ROB_TAG_W'(lane_ok[i]);
            cnt         = cnt + 6'(lane_ok[i]);
        end
        need      = cnt;
        tail_next = run;
    end

    // Not enough ROB space, hold the group
    assign stall = slots_valid && (need > rob_free);
    assign fire  = slots_valid && !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail       <= '0;
            disp_valid <= 1'b0;
            vld_q      <= '0;
        end else begin
            disp_valid <= fire;
            vld_q      <= fire ? lane_ok : '0;
            if (fire) begin
                tail <= tail_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            for (int i = 0; i < LANES; i++) begin
                disp_q[i] <= '{valid: lane_ok[i],
                               tag:   lane_tag[i],
                               pc:    slots[i].pc,
                               uop:   uops[i]};
            end
        end
    end

    // Valid bits come from the reset-cleared register
    always_comb begin
        disp = disp_q;
        for (int i = 0; i < LANES; i++) begin
            disp[i].valid = vld_q[i];
        end
    end

endmodule

//--- hdl/decode_stage.sv
module decode_stage #(
    parameter int LANES = 4
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            fetch_valid,
    input  logic [31:0]                     fetch_pc,
    input  logic [LANES-1:0][31:0]          fetch_insts,
    input  logic [LANES-1:0]                fetch_mask,
    input  logic [5:0]                      rob_free,
    output pipe_pkg::disp_uop_t [LANES-1:0] disp,
    output logic                            disp_valid,
    output logic                            stall
);

    import isa_pkg::*;
    import pipe_pkg::*;

    fetch_slot_t [LANES-1:0] slots;
    uop_t [LANES-1:0]        uops;
    logic                    slots_valid;

    fetch_align #(.LANES(LANES)) u_fetch_align (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_insts (fetch_insts),
        .fetch_mask  (fetch_mask),
        .stall       (stall),
        .slots       (slots),
        .slots_valid (slots_valid)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        inst_decoder u_dec (
            .inst (slots[i].inst),
            .uop  (uops[i])
        );
    end

    dispatch_unit #(.LANES(LANES)) u_dispatch (
        .clk         (clk),
        .arst_n      (arst_n),
        .slots       (slots),
        .slots_valid (slots_valid),
        .uops        (uops),
        .rob_free    (rob_free),
        .stall       (stall),
        .disp        (disp),
        .disp_valid  (disp_valid)
    );

endmodule

//--- bench/tb_decode_stage.sv
module tb_decode_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int LANES   = 4;
    localparam int N_DIR   = 36;
    localparam int N_RAND  = 64;
    localparam int LOW_LEN = 3;
    localparam int LIMIT   = 4 * (N_DIR + N_RAND) + N_RAND * (LOW_LEN + 1) + 100;

    // Opcode sweep for the directed groups with 16 encodings per opcode
    localparam logic [6:0] SWEEP_OPS [9] = '{R_OP, I_LOGIC_OP, I_MEM_OP, I_JALR_OP, S_OP,
                                            B_OP, U_LUI_OP, U_AUIPC_OP, J_OP};

    typedef struct packed {
        logic [31:0]            pc;
        logic [LANES-1:0][31:0] insts;
        logic [LANES-1:0]       mask;
        int                     accept;
        int                     stalls;
    } group_t;

    logic                    clk;
    logic                    arst_n;
    logic                    fetch_valid;
    logic [31:0]             fetch_pc;
    logic [LANES-1:0][31:0]  fetch_insts;
    logic [LANES-1:0]        fetch_mask;
    logic [5:0]              rob_free;
    disp_uop_t [LANES-1:0]   disp;
    logic                    disp_valid;
    logic                    stall;

    int          seed;
    int          low_cnt = 0;
    logic [5:0]  low_val = '0;
    int          cyc = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_done = 0;
    rob_tag_t    tag_next = '0;
    group_t      pending[$];

    decode_stage #(.LANES(LANES)) dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_insts (fetch_insts),
        .fetch_mask  (fetch_mask),
        .rob_free    (rob_free),
        .disp        (disp),
        .disp_valid  (disp_valid),
        .stall       (stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("timeout after %0d cycles, %0d groups never dispatched", cyc,
                     pending.size());
            $display("tests failed");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] got);
        n_checks++;
        assert (got === exp)
        else begin
            n_errors++;
            $display("ERR %s expected %0h got %0h", name, exp, got);
        end
    endtask

    task automatic check_cond(input logic cond, input string what);
        n_checks++;
        assert (cond)
        else begin
            n_errors++;
            $display("%s", what);
        end
    endtask

    function automatic uop_t set_format(uop_t u, fu_t fu, imm_sel_t isel, opa_sel_t a,
                                        opb_sel_t b, logic wr);
        uop_t v;
        v           = u;
        v.legal     = 1'b1;
        v.fu        = fu;
        v.imm_sel   = isel;
        v.opa_sel   = a;
        v.opb_sel   = b;
        v.reg_write = wr;
        return v;
    endfunction

    function automatic alu_op_t alu_code(logic [2:0] f3, logic alt);
        case (f3)
            3'h0:    return alt ? SUB : ADD;
            3'h1:    return SLL;
            3'h2:    return SLT;
            3'h3:    return SLTU;
            3'h4:    return XOR;
            3'h5:    return alt ? SRA : SRL;
            3'h6:    return OR;
            default: return AND;
        endcase
    endfunction

    // Expected decode straight from the RV32I encoding tables
    function automatic uop_t ref_decode(logic [31:0] w);
        uop_t       u;
        logic [2:0] f3;
        logic [6:0] f7;
        f3       = w[14:12];
        f7       = w[31:25];
        u        = '0;
        u.alu_op = ALU_NOP;
        u.lsq_op = LSQ_NOP;
        u.bra_op = BRA_NOP;
        u.rd     = w[11:7];
        u.rs1    = w[19:15];
        u.rs2    = w[24:20];
        case (w[6:0])
            R_OP: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'h0 || f3 == 3'h5))) begin
                    u        = set_format(u, FU_ALU, IMM_NONE, OPA_REG, OPB_REG, 1'b1);
                    u.alu_op = alu_code(f3, f7[5]);
                end
            end
            I_LOGIC_OP: begin
                if ((f3 != 3'h1 && f3 != 3'h5) || f7 == 7'h00 || (f3 == 3'h5 && f7 == 7'h20)) begin
                    u        = set_format(u, FU_ALU, IMM_I, OPA_REG, OPB_IMM, 1'b1);
                    u.alu_op = alu_code(f3, f3 == 3'h5 && f7[5]);
                end
            end
            I_MEM_OP: begin
                if (f3 != 3'h3 && f3 < 3'h6) begin
                    u = set_format(u, FU_LSQ, IMM_I, OPA_REG, OPB_NONE, 1'b1);
                    case (f3)
                        3'h0:    u.lsq_op = LB;
                        3'h1:    u.lsq_op = LH;
                        3'h2:    u.lsq_op = LW;
                        3'h4:    u.lsq_op = LBU;
                        default: u.lsq_op = LHU;
                    endcase
                end
            end
            S_OP: begin
                if (f3 < 3'h3) begin
                    u        = set_format(u, FU_LSQ, IMM_S, OPA_REG, OPB_REG, 1'b0);
                    u.lsq_op = (f3 == 3'h0) ? SB : (f3 == 3'h1) ? SH : SW;
                end
            end
            B_OP: begin
                if (f3 != 3'h2 && f3 != 3'h3) begin
                    u = set_format(u, FU_BRA, IMM_B, OPA_NONE, OPB_REG, 1'b0);
                    case (f3)
                        3'h0:    u.bra_op = BEQ;
                        3'h1:    u.bra_op = BNE;
                        3'h4:    u.bra_op = BLT;
                        3'h5:    u.bra_op = BGE;
                        3'h6:    u.bra_op = BLTU;
                        default: u.bra_op = BGEU;
                    endcase
                end
            end
            I_JALR_OP: begin
                if (f3 == 3'h0) begin
                    u        = set_format(u, FU_BRA, IMM_I, OPA_NONE, OPB_NONE, 1'b1);
                    u.bra_op = JALR;
                end
            end
            U_LUI_OP: begin
                u        = set_format(u, FU_ALU, IMM_U, OPA_NONE, OPB_IMM, 1'b1);
                u.alu_op = OUTB;
            end
            U_AUIPC_OP: begin
                u        = set_format(u, FU_ALU, IMM_U, OPA_PC, OPB_IMM, 1'b1);
                u.alu_op = ADD;
            end
            J_OP: begin
                u        = set_format(u, FU_BRA, IMM_J, OPA_NONE, OPB_NONE, 1'b1);
                u.bra_op = JAL;
            end
            default: ;
        endcase
        case (u.imm_sel)
            IMM_I:   u.imm = 32'($signed(w[31:20]));
            IMM_S:   u.imm = 32'($signed({w[31:25], w[11:7]}));
            IMM_B:   u.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            IMM_U:   u.imm = {w[31:12], 12'h000};
            IMM_J:   u.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            default: u.imm = '0;
        endcase
        return u;
    endfunction

    function automatic logic [31:0] sweep_inst(int n);
        logic [4:0] r;
        r = 5'(n);
        return {(n % 2 == 1) ? 7'h20 : 7'h00, r + 5'd3, ~r, 3'(n / 2), r, SWEEP_OPS[n / 16]};
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        int unsigned kind;
        w    = $random(seed);
        kind = {$random(seed)} % 8;
        if ({$random(seed)} % 8 == 0) begin
            // System, fence, M extension and a reserved branch
            case (w[5:4])
                2'd0: w[6:0] = 7'b1110011;
                2'd1: w[6:0] = 7'b0001111;
                2'd2: begin
                    w[6:0]   = R_OP;
                    w[31:25] = 7'h01;
                end
                default: begin
                    w[6:0]   = B_OP;
                    w[14:12] = 3'h2;
                end
            endcase
        end else begin
            case (kind)
                0: begin
                    w[6:0]   = R_OP;
                    w[31:25] = ((w[14:12] == 3'h0 || w[14:12] == 3'h5) && w[30]) ? 7'h20 : 7'h00;
                end
                1: begin
                    w[6:0] = I_LOGIC_OP;
                    if (w[14:12] == 3'h1) w[31:25] = 7'h00;
                    if (w[14:12] == 3'h5) w[31:25] = {1'b0, w[30], 5'b0};
                end
                2: begin
                    w[6:0] = I_MEM_OP;
                    if (w[14:12] == 3'h3 || w[14:12] > 3'h5) w[14:12] = 3'h2;
                end
                3: begin
                    w[6:0] = S_OP;
                    w[14]  = 1'b0;
                    if (w[13:12] == 2'b11) w[13:12] = 2'b10;
                end
                4: begin
                    w[6:0] = B_OP;
                    if (w[14:13] == 2'b01) w[14] = 1'b1;
                end
                5: begin
                    w[6:0]   = I_JALR_OP;
                    w[14:12] = 3'h0;
                end
                6:       w[6:0] = w[12] ? U_LUI_OP : U_AUIPC_OP;
                default: w[6:0] = J_OP;
            endcase
        end
        return w;
    endfunction

    // Compares a dispatched group with the oldest one accepted
    task automatic check_cycle();
        group_t g;
        uop_t   exp;
        logic   ok;
        int     need;
        if (disp_valid) begin
            n_done++;
            check_cond(pending.size() > 0, "disp_valid raised with no group pending");
            if (pending.size() > 0) begin
                g = pending.pop_front();
                compare("disp_valid cycle", g.accept + 1 + g.stalls, cyc);
                for (int i = 0; i < LANES; i++) begin
                    exp = ref_decode(g.insts[i]);
                    ok  = g.mask[i] && exp.legal;
                    compare($sformatf("disp[%0d].valid", i), ok, disp[i].valid);
                    compare($sformatf("disp[%0d].pc", i), g.pc + 32'(4 * i), disp[i].pc);
                    compare($sformatf("disp[%0d].uop", i), exp, disp[i].uop);
                    if (ok) begin
                        compare($sformatf("disp[%0d].tag", i), tag_next, disp[i].tag);
                        tag_next++;
                    end
                end
            end
        end else begin
            for (int i = 0; i < LANES; i++) begin
                compare($sformatf("disp[%0d].valid", i), 1'b0, disp[i].valid);
            end
        end
        need = 0;
        if (pending.size() > 0) begin
            for (int i = 0; i < LANES; i++) begin
                exp  = ref_decode(pending[0].insts[i]);
                need = need + int'(pending[0].mask[i] && exp.legal);
            end
        end
        compare("stall", pending.size() > 0 && need > int'(rob_free), stall);
        if (stall && pending.size() > 0) begin
            g = pending[0];
            g.stalls++;
            pending[0] = g;
        end
        if (fetch_valid && !stall) begin
            pending.push_back('{fetch_pc, fetch_insts, fetch_mask, cyc + 1, 0});
        end
    endtask

    always @(negedge clk) begin
        if (arst_n) check_cycle();
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (low_cnt > 0) begin
            rob_free = low_val;
            low_cnt--;
        end else begin
            rob_free = 6'd32;
        end
    endtask

    // Holds the group on the inputs until it is taken
    task automatic send_group(input logic [31:0] pc, input logic [LANES-1:0][31:0] words,
                              input logic [LANES-1:0] mask);
        logic took;
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        fetch_insts = words;
        fetch_mask  = mask;
        do begin
            @(negedge clk);
            took = !stall;
            next_cycle();
        end while (!took);
        fetch_valid = 1'b0;
    endtask

    initial begin
        logic [LANES-1:0][31:0] words;
        logic [31:0]            r;
        seed        = 32'h4f7bf11f;
        arst_n      = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_insts = '0;
        fetch_mask  = '0;
        rob_free    = 6'd32;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (3) next_cycle();
        for (int g = 0; g < N_DIR; g++) begin
            for (int i = 0; i < LANES; i++) begin
                words[i] = sweep_inst(g * LANES + i);
            end
            send_group(32'h0000_1000 + 32'(g * 16), words, '1);
        end
        for (int g = 0; g < N_RAND; g++) begin
            for (int i = 0; i < LANES; i++) begin
                words[i] = random_inst();
            end
            r = $random(seed);
            // Short window of ROB pressure
            if (r[10:8] == 3'd0) begin
                low_cnt  = LOW_LEN;
                low_val  = 6'(r[12:11] % 3);
                rob_free = low_val;
            end
            send_group($random(seed) & 32'hffff_fffc, words, r[3:0] | r[7:4]);
        end
        while (pending.size() != 0) next_cycle();
        repeat (4) next_cycle();
        compare("groups dispatched", N_DIR + N_RAND, n_done);
        $display("checks %0d  errors %0d  groups %0d", n_checks, n_errors, n_done);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- src.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_align.sv
hdl/inst_decoder.sv
hdl/dispatch_unit.sv
hdl/decode_stage.sv
bench/tb_decode_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_decode_stage -f src.f -o sim_decode_stage

./obj_dir/sim_decode_stage | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
